// File: Makefile
TOP := pwl_generator_tb

.PHONY: all lint clean

# Build, run, then decide on the log contents
all:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	@! grep -q "TEST FAIL" sim.log
	@grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: list.f
src/pwl_pkg.sv
src/segment_store.sv
src/ramp_base.sv
src/slope_offsets.sv
src/batch_assembler.sv
src/pwl_generator.sv
test/pwl_generator_chk.sv
test/pwl_generator_tb.sv

// File: src/batch_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module batch_assembler (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dac_rdy,
    input  pwl_pkg::base_beat_t  beat,
    input  pwl_pkg::lane_offs_t  offs,
    output pwl_pkg::batch_t      batch_out,
    output logic                 valid_batch_out,
    output logic                 halt
);
    import pwl_pkg::*;

    batch_t             lanes;
    logic signed [24:0] sum;
    logic               valid_r;
    logic               halt_r;

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            sum = $signed({beat.base[23], beat.base}) + $signed({offs[k][23], offs[k]});
            if (sum > SAMPLE_MAX) begin
                lanes[k] = SAMPLE_MAX;
            end else if (sum < SAMPLE_MIN) begin
                lanes[k] = SAMPLE_MIN;
            end else begin
                lanes[k] = sum[15:0];
            end
        end
    end

    // A held batch is shown on the next ready cycle and taken there
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= 1'b0;
            halt_r  <= 1'b0;
        end else if (dac_rdy) begin
            valid_r <= beat.valid;
            halt_r  <= beat.valid && beat.last_batch;
        end
    end

    always_ff @(posedge clk) begin
        if (dac_rdy) begin
            batch_out <= lanes;
        end
    end

    assign valid_batch_out = valid_r && dac_rdy;
    assign halt            = halt_r && dac_rdy;

endmodule

`default_nettype wire

// File: src/pwl_generator.sv
`timescale 1ns/1ps
`default_nettype none

module pwl_generator (
    input  logic                  clk,
    input  logic                  rst,
    input  pwl_pkg::dma_stream_t  dma,
    output logic                  dma_ready,
    input  logic                  run,
    output logic                  rdy_to_run,
    input  logic                  dac_rdy,
    output pwl_pkg::batch_t       batch_out,
    output logic                  valid_batch_out,
    output logic                  halt
);
    import pwl_pkg::*;

    logic                        busy;
    seg_addr_t                   seg_idx;
    segment_t                    seg;
    logic [$bits(seg_addr_t):0]  seg_count;
    base_beat_t                  beat;
    lane_offs_t                  offs;

    segment_store i_segment_store (
        .clk        (clk),
        .rst        (rst),
        .dma        (dma),
        .dma_ready  (dma_ready),
        .busy       (busy),
        .seg_idx    (seg_idx),
        .seg        (seg),
        .seg_count  (seg_count),
        .rdy_to_run (rdy_to_run)
    );

    ramp_base i_ramp_base (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .dac_rdy   (dac_rdy),
        .seg       (seg),
        .seg_count (seg_count),
        .seg_idx   (seg_idx),
        .busy      (busy),
        .beat      (beat)
    );

    // Loads while busy, which covers every FETCH cycle
    slope_offsets i_slope_offsets (
        .clk  (clk),
        .rst  (rst),
        .seg  (seg),
        .load (busy),
        .offs (offs)
    );

    batch_assembler i_batch_assembler (
        .clk             (clk),
        .rst             (rst),
        .dac_rdy         (dac_rdy),
        .beat            (beat),
        .offs            (offs),
        .batch_out       (batch_out),
        .valid_batch_out (valid_batch_out),
        .halt            (halt)
    );

endmodule

`default_nettype wire

// File: src/pwl_pkg.sv
`default_nettype none

package pwl_pkg;

    localparam int LANES = 16;
    localparam int SEG_DEPTH = 64;

    // Base saturation bound, far enough past the sample range that every lane still clamps
    localparam int BASE_LIM = 1 << 22;

    typedef logic signed [15:0] sample_t;
    typedef logic [47:0] dma_word_t;
    typedef logic [15:0] seg_len_t;
    typedef logic [$clog2(SEG_DEPTH)-1:0] seg_addr_t;
    typedef logic signed [23:0] base_acc_t;

    localparam sample_t SAMPLE_MAX = 16'sh7FFF;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

    typedef sample_t [LANES-1:0] batch_t;       // Lane 0 in the low bits

    // Same layout as the 48-bit stream word
    typedef struct packed {
        sample_t  start;
        sample_t  slope;
        seg_len_t len;
    } segment_t;

    typedef struct packed {
        dma_word_t data;
        logic      valid;
        logic      last;
    } dma_stream_t;

    typedef struct packed {
        base_acc_t base;
        logic      valid;
        logic      last_batch;
    } base_beat_t;

    typedef base_acc_t [LANES-1:0] lane_offs_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        RUN
    } gen_state_t;

endpackage

`default_nettype wire

// File: src/ramp_base.sv
`timescale 1ns/1ps
`default_nettype none

module ramp_base (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  run,
    input  logic                                  dac_rdy,
    input  pwl_pkg::segment_t                     seg,
    input  logic [$bits(pwl_pkg::seg_addr_t):0]   seg_count,
    output pwl_pkg::seg_addr_t                    seg_idx,
    output logic                                  busy,
    output pwl_pkg::base_beat_t                   beat
);
    import pwl_pkg::*;

    gen_state_t         state;
    seg_addr_t          idx;
    seg_addr_t          idx_nxt;
    seg_len_t           batch_cnt;
    base_acc_t          base;
    base_acc_t          base_step;
    base_acc_t          base_nxt;
    logic signed [24:0] base_sum;
    logic               last_seg;
    logic               seg_done;
    logic               step;

    assign last_seg  = ({1'b0, idx} == seg_count - 1'b1);
    assign seg_done  = (batch_cnt == seg.len - 1'b1);
    assign step      = (state == RUN) && dac_rdy;
    assign base_step = {{4{seg.slope[15]}}, seg.slope, 4'h0};    // 16 x slope per batch
    assign base_sum  = $signed({base[23], base}) + $signed({base_step[23], base_step});

    // Saturate so that long ramps keep clamping instead of wrapping
    always_comb begin
        if (base_sum > BASE_LIM) begin
            base_nxt = base_acc_t'(BASE_LIM);
        end else if (base_sum < -BASE_LIM) begin
            base_nxt = base_acc_t'(-BASE_LIM);
        end else begin
            base_nxt = base_sum[23:0];
        end
    end

    always_comb begin
        idx_nxt = idx;
        case (state)
            IDLE:    idx_nxt = '0;
            FETCH:   if (seg.len == '0) idx_nxt = idx + 1'b1;   // Skip empty segments
            RUN:     if (step && seg_done) idx_nxt = idx + 1'b1;
            default: idx_nxt = idx;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            idx       <= '0;
            batch_cnt <= '0;
            base      <= '0;
        end else begin
            idx <= idx_nxt;
            case (state)
                IDLE: begin
                    if (run && seg_count != '0) state <= FETCH;
                end
                FETCH: begin
                    batch_cnt <= '0;
                    base      <= base_acc_t'(seg.start);
                    if (seg.len != '0) begin
                        state <= RUN;
                    end else if (last_seg) begin
                        state <= IDLE;          // Table ended in empty segments
                    end
                end
                RUN: begin
                    if (step) begin
                        base      <= base_nxt;
                        batch_cnt <= batch_cnt + 1'b1;
                        if (seg_done) state <= last_seg ? IDLE : FETCH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign seg_idx         = idx_nxt;
    assign busy            = (state != IDLE);
    assign beat.base       = base;
    assign beat.valid      = (state == RUN);
    assign beat.last_batch = (state == RUN) && seg_done && last_seg;

endmodule

`default_nettype wire

// File: src/segment_store.sv
`timescale 1ns/1ps
`default_nettype none

module segment_store (
    input  logic                                  clk,
    input  logic                                  rst,
    input  pwl_pkg::dma_stream_t                  dma,
    output logic                                  dma_ready,
    input  logic                                  busy,
    input  pwl_pkg::seg_addr_t                    seg_idx,
    output pwl_pkg::segment_t                     seg,
    output logic [$bits(pwl_pkg::seg_addr_t):0]   seg_count,
    output logic                                  rdy_to_run
);
    import pwl_pkg::*;

    segment_t  seg_mem [SEG_DEPTH];
    seg_addr_t wr_ptr;
    logic      ready_en;
    logic      wr_en;

    // The table only takes words while the generator is idle
    assign dma_ready  = ready_en && !busy;
    assign wr_en      = dma.valid && dma_ready;
    assign rdy_to_run = (seg_count != '0) && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_en  <= 1'b0;
            wr_ptr    <= '0;
            seg_count <= '0;
        end else begin
            ready_en <= 1'b1;                   // Opens one cycle after reset
            if (wr_en) begin
                if (dma.last) begin
                    wr_ptr    <= '0;
                    seg_count <= {1'b0, wr_ptr} + 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // Table write and registered read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            seg_mem[wr_ptr] <= segment_t'(dma.data);
        end
        seg <= seg_mem[seg_idx];                // seg_idx is the next index, so seg tracks it
    end

endmodule

`default_nettype wire

// File: src/slope_offsets.sv
`timescale 1ns/1ps
`default_nettype none

module slope_offsets (
    input  logic                 clk,
    input  logic                 rst,
    input  pwl_pkg::segment_t    seg,
    input  logic                 load,
    output pwl_pkg::lane_offs_t  offs
);
    import pwl_pkg::*;

    base_acc_t  slope_ext;
    lane_offs_t offs_nxt;

    assign slope_ext = base_acc_t'(seg.slope);

    // Lane k sits k samples into the batch
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            offs_nxt[k] = slope_ext * base_acc_t'(k);
        end
    end

    // seg is steady through a segment, so the table is too
    always_ff @(posedge clk) begin
        if (rst) begin
            offs <= '0;
        end else if (load) begin
            offs <= offs_nxt;
        end
    end

endmodule

`default_nettype wire

// File: test/pwl_generator_chk.sv
`timescale 1ns/1ps
`default_nettype none

module pwl_generator_chk (
    input logic clk,
    input logic rst,
    input logic run,
    input logic rdy_to_run,
    input logic busy,
    input logic dma_ready,
    input logic dac_rdy,
    input logic valid_batch_out,
    input logic halt
);
    int fail_cnt = 0;

    a_valid_with_ready: assert property (@(posedge clk) disable iff (rst)
        valid_batch_out |-> dac_rdy)
        else begin
            $error("valid_batch_out high while dac_rdy is low");
            fail_cnt++;
        end

    a_halt_with_valid: assert property (@(posedge clk) disable iff (rst)
        halt |-> valid_batch_out)
        else begin
            $error("halt high without valid_batch_out");
            fail_cnt++;
        end

    // A run is in progress from the cycle after acceptance and while batches before the last still come
    a_no_run_while_busy: assert property (@(posedge clk) disable iff (rst)
        $past(run && rdy_to_run) || (valid_batch_out && !halt) |-> !rdy_to_run)
        else begin
            $error("rdy_to_run high while a run is in progress");
            fail_cnt++;
        end

    // The generator only starts on an accepted run pulse
    a_start_on_run: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(run && rdy_to_run))
        else begin
            $error("generator started without an accepted run");
            fail_cnt++;
        end

    a_dma_closed_while_busy: assert property (@(posedge clk) disable iff (rst)
        $past(run && rdy_to_run) || (valid_batch_out && !halt) |-> !dma_ready)
        else begin
            $error("dma_ready high while a run is in progress");
            fail_cnt++;
        end

    a_no_early_valid: assert property (@(posedge clk) disable iff (rst)
        $past(run && rdy_to_run) || $past(run && rdy_to_run, 2) |-> !valid_batch_out)
        else begin
            $error("valid_batch_out earlier than 3 cycles after run");
            fail_cnt++;
        end

    a_first_valid: assert property (@(posedge clk) disable iff (rst)
        $past(run && rdy_to_run, 3) && $past(dac_rdy) && dac_rdy |-> valid_batch_out)
        else begin
            $error("no valid_batch_out 3 cycles after run");
            fail_cnt++;
        end

endmodule

bind pwl_generator pwl_generator_chk i_pwl_generator_chk (
    .clk             (clk),
    .rst             (rst),
    .run             (run),
    .rdy_to_run      (rdy_to_run),
    .busy            (busy),
    .dma_ready       (dma_ready),
    .dac_rdy         (dac_rdy),
    .valid_batch_out (valid_batch_out),
    .halt            (halt)
);

`default_nettype wire

// File: test/pwl_generator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pwl_generator_tb;
    import pwl_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    logic        clk;
    logic        rst = 1'b1;
    dma_stream_t dma = '0;
    logic        dma_ready;
    logic        run = 1'b0;
    logic        rdy_to_run;
    logic        dac_rdy = 1'b0;
    batch_t      batch_out;
    logic        valid_batch_out;
    logic        halt;

    logic [31:0] lfsr = 32'h83887061;
    logic        rand_ready = 1'b0;
    logic        halt_seen = 1'b0;
    int          got_cnt = 0;
    int          err_cnt = 0;
    int          test_cnt = 0;
    int          test_fail = 0;
    segment_t    tbl[$];
    batch_t      exp_q[$];
    batch_t      exp_batch;

    pwl_generator i_pwl_generator (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR with taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int errors();
        return err_cnt + i_pwl_generator.i_pwl_generator_chk.fail_cnt;
    endfunction

    // Lane rule start + slope x sample index, clamped to 16 bits
    function automatic sample_t ref_sample(input segment_t s, input int idx);
        longint v;
        v = longint'(s.start) + longint'(s.slope) * idx;
        if (v > 32767) return 16'sh7FFF;
        if (v < -32768) return 16'sh8000;
        return sample_t'(v);
    endfunction

    task automatic build_model(output int total);
        batch_t b;
        total = 0;
        exp_q.delete();
        foreach (tbl[i]) begin
            for (int n = 0; n < int'(tbl[i].len); n++) begin
                for (int k = 0; k < LANES; k++) begin
                    b[k] = ref_sample(tbl[i], 16 * n + k);
                end
                exp_q.push_back(b);
                total++;
            end
        end
    endtask

    task automatic add_seg(input logic [15:0] start, input logic [15:0] slope, input int len);
        segment_t s;
        s.start = start;
        s.slope = slope;
        s.len = seg_len_t'(len);
        tbl.push_back(s);
    endtask

    always @(posedge clk) begin
        if (rand_ready) dac_rdy <= (rand_bits(1) != 0);
        else dac_rdy <= 1'b1;
    end

    // Outputs are settled at the falling edge and move on the next rising edge
    always @(negedge clk) begin
        if (!rst && valid_batch_out) begin
            got_cnt++;
            if (exp_q.size() == 0) begin
                $display("unexpected batch on valid_batch_out, the model has none left");
                err_cnt++;
            end else begin
                exp_batch = exp_q.pop_front();
                assert (batch_out === exp_batch) else begin
                    $display("ERROR batch_out got %h expected %h", batch_out, exp_batch);
                    err_cnt++;
                end
                assert (halt === (exp_q.size() == 0)) else begin
                    $display("ERROR halt got %h expected %h", halt, exp_q.size() == 0);
                    err_cnt++;
                end
            end
            if (halt) halt_seen = 1'b1;
        end
    end

    task automatic send_packet();
        int t;
        foreach (tbl[i]) begin
            @(posedge clk);
            dma <= '{data: dma_word_t'(tbl[i]), valid: 1'b1, last: (i == tbl.size() - 1)};
            t = 0;
            @(negedge clk);
            while (!dma_ready && t < WAIT_LIMIT) begin
                @(negedge clk);
                t++;
            end
            if (!dma_ready) begin
                $display("dma_ready never came up for word %0d", i);
                err_cnt++;
            end
        end
        @(posedge clk);
        dma.valid <= 1'b0;
    endtask

    task automatic run_table(input bit random_ready, input bit check_latency);
        int total;
        int t;
        int lat;
        build_model(total);
        got_cnt = 0;
        halt_seen = 1'b0;
        t = 0;
        @(negedge clk);
        while (!rdy_to_run && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!rdy_to_run) begin
            $display("rdy_to_run never came up");
            err_cnt++;
        end
        rand_ready = random_ready;
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        t = 0;
        lat = 0;
        while (!halt_seen && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
            if (lat == 0 && valid_batch_out) lat = t;
        end
        rand_ready = 1'b0;
        if (!halt_seen) begin
            $display("halt never came after run");
            err_cnt++;
        end
        if (check_latency) begin
            assert (lat == 3) else begin
                $display("ERROR first valid_batch_out latency got %h expected %h", lat, 3);
                err_cnt++;
            end
        end
        assert (got_cnt == total) else begin
            $display("ERROR valid_batch_out count got %h expected %h", got_cnt, total);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (errors() == errs_before) begin
            $display("%s ok", name);
        end else begin
            test_fail++;
            $display("%s failed with %0d errors", name, errors() - errs_before);
        end
    endtask

    initial begin
        int e;
        logic [31:0] r;
        logic [15:0] st;
        int len;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        e = errors();
        add_seg(16'hFC18, 16'h0025, 4);
        send_packet();
        run_table(1'b0, 1'b1);
        finish_test("single ramp", e);

        e = errors();
        tbl.delete();
        for (int i = 0; i < 5; i++) begin
            r = rand_bits(16);
            st = r[15:0];
            r = rand_bits(10);
            len = (i == 2) ? 0 : 1 + int'(rand_bits(3));  // Segment 2 is empty
            add_seg(st, {{6{r[9]}}, r[9:0]}, len);
        end
        send_packet();
        run_table(1'b0, 1'b1);
        finish_test("multi segment", e);

        e = errors();
        run_table(1'b1, 1'b0);
        finish_test("back pressure", e);

        e = errors();
        tbl.delete();
        add_seg(16'h7000, 16'h0400, 3);     // Climbs past 16'h7FFF from lane 4
        add_seg(16'h9000, 16'hFA00, 3);     // Falls past 16'h8000 from lane 3
        send_packet();
        run_table(1'b0, 1'b1);
        finish_test("clamping", e);

        e = errors();
        tbl.delete();
        add_seg(16'h0100, 16'h0003, 2);
        add_seg(16'hF000, 16'h0010, 1);
        add_seg(16'h0000, 16'hFFFF, 3);
        send_packet();
        run_table(1'b0, 1'b1);
        run_table(1'b0, 1'b1);
        finish_test("reload and rerun", e);

        $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, errors());
        if (errors() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
